/* c16_mem_pkg.sv */
// Shared definitions for the C16/Plus-4 memory subsystem
// Bus widths, download index codes and ROM slot numbers
// BASIC pointer table written after a PRG download
// ROM bank choice type and the download address union
`default_nettype none

package c16_mem_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths

	localparam int CPU_AW = 16;
	localparam int DATA_W = 8;
	localparam int DL_AW  = 25;
	localparam int ROM_AW = 14;
	localparam int SLOT_W = 11;

	////////////////////////////////////////////////////////////////////////////
	// Download port

	// Index codes sent by the host with each file
	localparam logic [7:0] IDX_PRG = 8'h01;
	localparam logic [7:0] IDX_ROM = 8'h03;
	localparam logic [7:0] IDX_CRT = 8'h81;

	// 16 KB slots inside a system ROM file
	localparam logic [SLOT_W-1:0] SLOT_KERNAL = 11'd1;
	localparam logic [SLOT_W-1:0] SLOT_BASIC  = 11'd2;
	localparam logic [SLOT_W-1:0] SLOT_FUNCL  = 11'd3;
	localparam logic [SLOT_W-1:0] SLOT_FUNCH  = 11'd4;

	// Slots inside a cartridge file
	localparam logic [SLOT_W-1:0] SLOT_CART_L = 11'd0;
	localparam logic [SLOT_W-1:0] SLOT_CART_H = 11'd1;

	////////////////////////////////////////////////////////////////////////////
	// CPU address map

	localparam logic [11:0] BANK_PAGE   = 12'hFDD;
	localparam logic [7:0]  KERNAL_PAGE = 8'hFC;

	// BASIC start/end pointers, low byte at even positions
	localparam int PTR_COUNT = 8;
	localparam logic [CPU_AW-1:0] PTR_ADDR [PTR_COUNT] = '{
		16'h002D, 16'h002E, 16'h002F, 16'h0030,
		16'h0031, 16'h0032, 16'h009D, 16'h009E
	};

	////////////////////////////////////////////////////////////////////////////
	// Types

	typedef enum logic [1:0] {
		BANK_SYSTEM = 2'd0,
		BANK_CART   = 2'd1,
		BANK_FUNC   = 2'd2,
		BANK_RSVD   = 2'd3
	} bank_sel_t;

	typedef struct packed {
		logic [SLOT_W-1:0] slot;
		logic [ROM_AW-1:0] offset;
	} dl_slot_t;

	// Download address as a flat byte count or as slot plus offset
	typedef union packed {
		logic [DL_AW-1:0] flat;
		dl_slot_t         sel;
	} dl_addr_u;

endpackage

`default_nettype wire

/* prg_loader.sv */
// PRG download loader
// Parses the two-byte load address, then turns each body byte into a
// RAM write request; when the download ends it writes the end address
// into the BASIC pointer locations
`timescale 1ns/1ps
`default_nettype none

module prg_loader (
	input  wire                            clk_sys,
	input  wire                            reset,
	input  wire                            dl_active_i,
	input  wire  [7:0]                     dl_index_i,
	input  wire                            dl_wr_i,
	input  wire  [c16_mem_pkg::DL_AW-1:0]  dl_addr_i,
	input  wire  [c16_mem_pkg::DATA_W-1:0] dl_data_i,
	input  wire                            ld_gnt_i,
	output logic                           ld_req_o,
	output logic [c16_mem_pkg::CPU_AW-1:0] ld_addr_o,
	output logic [c16_mem_pkg::DATA_W-1:0] ld_data_o,
	output logic                           dl_wait_o
);
	import c16_mem_pkg::*;

	dl_addr_u          dl_word;
	logic              is_prg;
	logic              dl_write;
	logic              hdr_lo;
	logic              hdr_hi;
	logic              body_wr;
	logic              active_d;
	logic              dl_end;
	logic [CPU_AW-1:0] addr_cnt;
	logic              fix_busy;
	logic [3:0]        step;
	logic              step_done;
	logic              fix_issue;

	assign dl_word  = dl_addr_i;
	assign is_prg   = (dl_index_i == IDX_PRG);
	assign dl_write = dl_active_i & is_prg & dl_wr_i;
	assign hdr_lo   = (dl_word.flat == 25'd0);
	assign hdr_hi   = (dl_word.flat == 25'd1);
	assign body_wr  = dl_write & ~hdr_lo & ~hdr_hi;

	// Falling edge of the download level
	assign dl_end = active_d & ~dl_active_i & is_prg;

	assign step_done = (step == 4'(PTR_COUNT));
	// Next pointer write goes out once the previous one was granted
	assign fix_issue = fix_busy & ~ld_req_o & ~step_done;

	// Host must hold off while a request or the fix-up is pending
	assign dl_wait_o = ld_req_o | fix_busy | dl_end;

	////////////////////////////////////////////////////////////////////////////
	// Request handshake and fix-up sequencing

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_d <= 1'b0;
			ld_req_o <= 1'b0;
			fix_busy <= 1'b0;
			step     <= 4'd0;
		end else begin
			active_d <= dl_active_i;
			if (ld_gnt_i)
				ld_req_o <= 1'b0;
			if (body_wr | fix_issue)
				ld_req_o <= 1'b1;

			if (dl_end) begin
				fix_busy <= 1'b1;
				step     <= 4'd0;
			end else if (fix_issue) begin
				step <= step + 4'd1;
			end else if (fix_busy && step_done && !ld_req_o) begin
				fix_busy <= 1'b0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Address counter and request payload

	always_ff @(posedge clk_sys) begin
		if (dl_write) begin
			if (hdr_lo) begin
				addr_cnt[7:0] <= dl_data_i;
			end else if (hdr_hi) begin
				addr_cnt[15:8] <= dl_data_i;
			end else begin
				ld_addr_o <= addr_cnt;
				ld_data_o <= dl_data_i;
				addr_cnt  <= addr_cnt + 16'd1;
			end
		end else if (fix_issue) begin
			// Counter now holds the end address
			ld_addr_o <= PTR_ADDR[step[2:0]];
			ld_data_o <= step[0] ? addr_cnt[15:8] : addr_cnt[7:0];
		end
	end

endmodule

`default_nettype wire

/* ram_arbiter.sv */
// Main RAM port arbiter
// CPU bus has priority: reads while its select is low, then the write
// captured from that access; the loader gets the remaining cycles
`timescale 1ns/1ps
`default_nettype none

module ram_arbiter (
	input  wire                            clk_sys,
	input  wire                            reset,
	input  wire  [c16_mem_pkg::CPU_AW-1:0] cpu_addr_i,
	input  wire  [c16_mem_pkg::DATA_W-1:0] cpu_wdata_i,
	input  wire                            cpu_rnw_i,
	input  wire                            cs_ram_n_i,
	input  wire                            ld_req_i,
	input  wire  [c16_mem_pkg::CPU_AW-1:0] ld_addr_i,
	input  wire  [c16_mem_pkg::DATA_W-1:0] ld_data_i,
	output logic                           ld_gnt_o,
	output logic [c16_mem_pkg::CPU_AW-1:0] ram_addr_o,
	output logic [c16_mem_pkg::DATA_W-1:0] ram_wdata_o,
	output logic                           ram_we_o
);
	import c16_mem_pkg::*;

	logic              cs_d;
	logic              cpu_we;
	logic [CPU_AW-1:0] cap_addr;
	logic [DATA_W-1:0] cap_data;
	logic              cap_rnw;

	// Write slot follows the rising edge of the RAM select
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cs_d   <= 1'b1;
			cpu_we <= 1'b0;
		end else begin
			cs_d   <= cs_ram_n_i;
			cpu_we <= cs_ram_n_i & ~cs_d & ~cap_rnw;
		end
	end

	// Last address and data seen during the access
	always_ff @(posedge clk_sys) begin
		if (!cs_ram_n_i) begin
			cap_addr <= cpu_addr_i;
			cap_data <= cpu_wdata_i;
			cap_rnw  <= cpu_rnw_i;
		end
	end

	always_comb begin
		ram_addr_o  = cpu_addr_i;
		ram_wdata_o = cap_data;
		ram_we_o    = 1'b0;
		ld_gnt_o    = 1'b0;
		if (!cs_ram_n_i) begin
			ram_addr_o = cpu_addr_i;
		end else if (cpu_we) begin
			ram_addr_o = cap_addr;
			ram_we_o   = 1'b1;
		end else if (ld_req_i) begin
			ram_addr_o  = ld_addr_i;
			ram_wdata_o = ld_data_i;
			ram_we_o    = 1'b1;
			ld_gnt_o    = 1'b1;
		end
	end

endmodule

`default_nettype wire

/* main_ram.sv */
// Main RAM
// Single-port synchronous array, read data registered one cycle
// after the address
`timescale 1ns/1ps
`default_nettype none

module main_ram #(
	parameter int WORDS = 65536
) (
	input  wire                            clk_sys,
	input  wire  [c16_mem_pkg::CPU_AW-1:0] addr_i,
	input  wire  [c16_mem_pkg::DATA_W-1:0] wdata_i,
	input  wire                            we_i,
	output logic [c16_mem_pkg::DATA_W-1:0] rdata_o
);
	localparam int AW = $clog2(WORDS);

	logic [c16_mem_pkg::DATA_W-1:0] mem [WORDS];
	logic [AW-1:0]                  word_addr;

	assign word_addr = addr_i[AW-1:0];

	always_ff @(posedge clk_sys) begin
		if (we_i)
			mem[word_addr] <= wdata_i;
		// Read returns the old contents on a write cycle
		rdata_o <= mem[word_addr];
	end

endmodule

`default_nettype wire

/* rom_store.sv */
// ROM store
// Kernal, BASIC, function low/high and cartridge low/high images,
// written from the download port and read through the chip selects
// Cartridge presence flags
`timescale 1ns/1ps
`default_nettype none

module rom_store #(
	parameter int WORDS = 16384
) (
	input  wire                              clk_sys,
	input  wire                              reset,
	input  wire  [7:0]                       dl_index_i,
	input  wire                              dl_wr_i,
	input  wire  [c16_mem_pkg::DL_AW-1:0]    dl_addr_i,
	input  wire  [c16_mem_pkg::DATA_W-1:0]   dl_data_i,
	input  wire  [c16_mem_pkg::CPU_AW-1:0]   cpu_addr_i,
	input  wire                              cs0_n_i,
	input  wire                              cs1_n_i,
	input  wire  c16_mem_pkg::bank_sel_t     roml_i,
	input  wire  c16_mem_pkg::bank_sel_t     romh_i,
	input  wire                              kern_i,
	output logic [c16_mem_pkg::DATA_W-1:0]   rom_rdata_o,
	output logic                             cart_l_o,
	output logic                             cart_h_o
);
	import c16_mem_pkg::*;

	localparam int AW     = $clog2(WORDS);
	localparam int IMG_N  = 6;

	// Image positions
	localparam int IMG_KERNAL = 0;
	localparam int IMG_BASIC  = 1;
	localparam int IMG_FUNCL  = 2;
	localparam int IMG_FUNCH  = 3;
	localparam int IMG_CART_L = 4;
	localparam int IMG_CART_H = 5;

	dl_addr_u          dl_word;
	logic              is_rom;
	logic              is_crt;
	logic [AW-1:0]     wr_addr;
	logic [AW-1:0]     rd_addr;
	logic [IMG_N-1:0]  img_we;
	logic [IMG_N-1:0]  img_sel;
	wire  [DATA_W-1:0] img_q [IMG_N];

	assign dl_word = dl_addr_i;
	assign is_rom  = (dl_index_i == IDX_ROM);
	assign is_crt  = (dl_index_i == IDX_CRT);
	assign wr_addr = dl_word.sel.offset[AW-1:0];
	assign rd_addr = cpu_addr_i[AW-1:0];

	always_comb begin
		img_we[IMG_KERNAL] = dl_wr_i & is_rom & (dl_word.sel.slot == SLOT_KERNAL);
		img_we[IMG_BASIC]  = dl_wr_i & is_rom & (dl_word.sel.slot == SLOT_BASIC);
		img_we[IMG_FUNCL]  = dl_wr_i & is_rom & (dl_word.sel.slot == SLOT_FUNCL);
		img_we[IMG_FUNCH]  = dl_wr_i & is_rom & (dl_word.sel.slot == SLOT_FUNCH);
		img_we[IMG_CART_L] = dl_wr_i & is_crt & (dl_word.sel.slot == SLOT_CART_L);
		img_we[IMG_CART_H] = dl_wr_i & is_crt & (dl_word.sel.slot == SLOT_CART_H);
	end

	// The $FCxx page always shows the kernal, whatever romh says
	always_comb begin
		img_sel[IMG_KERNAL] = ~cs1_n_i & ((romh_i == BANK_SYSTEM) | kern_i);
		img_sel[IMG_BASIC]  = ~cs0_n_i & (roml_i == BANK_SYSTEM);
		img_sel[IMG_FUNCL]  = ~cs0_n_i & (roml_i == BANK_FUNC);
		img_sel[IMG_FUNCH]  = ~cs1_n_i & (romh_i == BANK_FUNC) & ~kern_i;
		img_sel[IMG_CART_L] = ~cs0_n_i & (roml_i == BANK_CART) & cart_l_o;
		img_sel[IMG_CART_H] = ~cs1_n_i & (romh_i == BANK_CART) & ~kern_i & cart_h_o;
	end

	////////////////////////////////////////////////////////////////////////////
	// Image arrays

	for (genvar i = 0; i < IMG_N; i++) begin : g_img
		logic [DATA_W-1:0] mem [WORDS];
		logic [DATA_W-1:0] q;

		always_ff @(posedge clk_sys) begin
			if (img_we[i])
				mem[wr_addr] <= dl_data_i;
			// Unselected image floats high on the open bus
			if (img_sel[i])
				q <= mem[rd_addr];
			else
				q <= '1;
		end

		assign img_q[i] = q;
	end

	always_comb begin
		rom_rdata_o = '1;
		for (int i = 0; i < IMG_N; i++)
			rom_rdata_o = rom_rdata_o & img_q[i];
	end

	// Set by the first byte written into each cartridge half
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cart_l_o <= 1'b0;
			cart_h_o <= 1'b0;
		end else begin
			if (img_we[IMG_CART_L])
				cart_l_o <= 1'b1;
			if (img_we[IMG_CART_H])
				cart_h_o <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* bank_ctrl.sv */
// Plus-4 ROM bank control
// Model latch, bank register written by I/O accesses at $FDDx and
// the kernal page override
`timescale 1ns/1ps
`default_nettype none

module bank_ctrl (
	input  wire                            clk_sys,
	input  wire                            reset,
	input  wire                            model_i,
	input  wire  [c16_mem_pkg::CPU_AW-1:0] cpu_addr_i,
	input  wire                            cpu_rnw_i,
	input  wire                            cs_io_n_i,
	output c16_mem_pkg::bank_sel_t         roml_o,
	output c16_mem_pkg::bank_sel_t         romh_o,
	output logic                           kern_o
);
	import c16_mem_pkg::*;

	logic              model_q;
	logic              io_d;
	logic [CPU_AW-1:0] io_addr;
	logic              io_rnw;
	logic              bank_wr;

	// Address and direction of the current I/O access
	always_ff @(posedge clk_sys) begin
		if (!cs_io_n_i) begin
			io_addr <= cpu_addr_i;
			io_rnw  <= cpu_rnw_i;
		end
	end

	// End of an I/O write to the bank page, Plus-4 only
	assign bank_wr = cs_io_n_i & ~io_d & ~io_rnw & model_q
		& (io_addr[15:4] == BANK_PAGE);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q <= model_i;
			io_d    <= 1'b1;
			roml_o  <= BANK_SYSTEM;
			romh_o  <= BANK_SYSTEM;
		end else begin
			io_d <= cs_io_n_i;
			if (bank_wr) begin
				roml_o <= bank_sel_t'(io_addr[1:0]);
				romh_o <= bank_sel_t'(io_addr[3:2]);
			end
		end
	end

	assign kern_o = (cpu_addr_i[15:8] == KERNAL_PAGE);

endmodule

`default_nettype wire

/* c16_mem_top.sv */
// C16/Plus-4 memory and banking subsystem, top level
// PRG loader and CPU bus share the main RAM through the arbiter
// ROM store, bank register and the open-bus read data path
`timescale 1ns/1ps
`default_nettype none

module c16_mem_top #(
	parameter int RAM_WORDS = 65536,
	parameter int ROM_WORDS = 16384
) (
	input  wire                            clk_sys,
	input  wire                            reset,
	input  wire                            dl_active_i,
	input  wire  [7:0]                     dl_index_i,
	input  wire                            dl_wr_i,
	input  wire  [c16_mem_pkg::DL_AW-1:0]  dl_addr_i,
	input  wire  [c16_mem_pkg::DATA_W-1:0] dl_data_i,
	input  wire  [c16_mem_pkg::CPU_AW-1:0] cpu_addr_i,
	input  wire  [c16_mem_pkg::DATA_W-1:0] cpu_wdata_i,
	input  wire                            cpu_rnw_i,
	input  wire                            cs_ram_n_i,
	input  wire                            cs0_n_i,
	input  wire                            cs1_n_i,
	input  wire                            cs_io_n_i,
	input  wire                            model_i,
	output logic [c16_mem_pkg::DATA_W-1:0] cpu_rdata_o,
	output logic                           dl_wait_o
);
	import c16_mem_pkg::*;

	logic              ld_req;
	logic              ld_gnt;
	logic [CPU_AW-1:0] ld_addr;
	logic [DATA_W-1:0] ld_data;
	logic [CPU_AW-1:0] ram_addr;
	logic [DATA_W-1:0] ram_wdata;
	logic              ram_we;
	logic [DATA_W-1:0] ram_rdata;
	logic [DATA_W-1:0] rom_rdata;
	bank_sel_t         roml;
	bank_sel_t         romh;
	logic              kern;
	logic              ram_sel_d;
	logic [DATA_W-1:0] ram_bus;

	prg_loader u_loader (
		.clk_sys(clk_sys), .reset(reset),
		.dl_active_i(dl_active_i), .dl_index_i(dl_index_i), .dl_wr_i(dl_wr_i),
		.dl_addr_i(dl_addr_i), .dl_data_i(dl_data_i), .ld_gnt_i(ld_gnt),
		.ld_req_o(ld_req), .ld_addr_o(ld_addr), .ld_data_o(ld_data),
		.dl_wait_o(dl_wait_o)
	);

	ram_arbiter u_arbiter (
		.clk_sys(clk_sys), .reset(reset),
		.cpu_addr_i(cpu_addr_i), .cpu_wdata_i(cpu_wdata_i), .cpu_rnw_i(cpu_rnw_i),
		.cs_ram_n_i(cs_ram_n_i), .ld_req_i(ld_req), .ld_addr_i(ld_addr),
		.ld_data_i(ld_data), .ld_gnt_o(ld_gnt), .ram_addr_o(ram_addr),
		.ram_wdata_o(ram_wdata), .ram_we_o(ram_we)
	);

	main_ram #(.WORDS(RAM_WORDS)) u_ram (
		.clk_sys(clk_sys), .addr_i(ram_addr), .wdata_i(ram_wdata),
		.we_i(ram_we), .rdata_o(ram_rdata)
	);

	rom_store #(.WORDS(ROM_WORDS)) u_roms (
		.clk_sys(clk_sys), .reset(reset),
		.dl_index_i(dl_index_i), .dl_wr_i(dl_wr_i), .dl_addr_i(dl_addr_i),
		.dl_data_i(dl_data_i), .cpu_addr_i(cpu_addr_i), .cs0_n_i(cs0_n_i),
		.cs1_n_i(cs1_n_i), .roml_i(roml), .romh_i(romh), .kern_i(kern),
		.rom_rdata_o(rom_rdata), .cart_l_o(), .cart_h_o()
	);

	bank_ctrl u_bank (
		.clk_sys(clk_sys), .reset(reset), .model_i(model_i),
		.cpu_addr_i(cpu_addr_i), .cpu_rnw_i(cpu_rnw_i), .cs_io_n_i(cs_io_n_i),
		.roml_o(roml), .romh_o(romh), .kern_o(kern)
	);

	////////////////////////////////////////////////////////////////////////////
	// Read data bus

	// RAM select delayed to line up with the registered RAM output
	always_ff @(posedge clk_sys) begin
		if (reset)
			ram_sel_d <= 1'b0;
		else
			ram_sel_d <= ~cs_ram_n_i;
	end

	assign ram_bus = ram_sel_d ? ram_rdata : {DATA_W{1'b1}};

	// Open bus reads $FF and every selected source pulls bits low
	always_ff @(posedge clk_sys) begin
		cpu_rdata_o <= ram_bus & rom_rdata;
	end

endmodule

`default_nettype wire

/* tb_c16_mem.sv */
// Directed testbench for the C16/Plus-4 memory subsystem
// Clock, reset, watchdog, download port and CPU bus tasks
// Tests for PRG loading, RAM arbitration, ROM selection and banking
`timescale 1ns/1ps
`default_nettype none

module tb_c16_mem;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 16;
	localparam int PRG_LEN      = 40;
	localparam int RAND_LEN     = 32;
	localparam int MIX_LEN      = 24;
	localparam int ROM_LEN      = 8;
	localparam int OP_CYCLES    = 8;
	// Strobes plus bus accesses of all tests with a factor of two as margin
	localparam int TOTAL_OPS    = (2 * PRG_LEN + 12) + 2 * RAND_LEN + (5 * MIX_LEN + 12)
		+ 5 * ROM_LEN + 9 * ROM_LEN + 4;
	localparam int WATCHDOG_NS  = 2 * (TOTAL_OPS * OP_CYCLES + 3 * RESET_CYCLES) * CLK_PERIOD;

	localparam logic [7:0]  PRG_INDEX    = 8'h01;
	localparam logic [7:0]  ROM_INDEX    = 8'h03;
	localparam logic [7:0]  CRT_INDEX    = 8'h81;
	localparam logic [15:0] MIX_PRG_BASE = 16'h3000;
	localparam logic [15:0] MIX_CPU_BASE = 16'h5000;
	localparam logic [15:0] PTR_LOC [8]  = '{
		16'h002D, 16'h002E, 16'h002F, 16'h0030,
		16'h0031, 16'h0032, 16'h009D, 16'h009E
	};

	// Chip select choice for the bus tasks
	localparam int SEL_RAM = 0;
	localparam int SEL_CS0 = 1;
	localparam int SEL_CS1 = 2;
	localparam int SEL_IO  = 3;

	// Reference image slices
	localparam int IMG_KERNAL    = 0;
	localparam int IMG_KERNAL_FC = 1;
	localparam int IMG_BASIC     = 2;
	localparam int IMG_CART_L    = 3;
	localparam int IMG_CART_H    = 4;

	logic        clk_sys = 1'b0;
	logic        reset;
	logic        dl_active_i;
	logic [7:0]  dl_index_i;
	logic        dl_wr_i;
	logic [24:0] dl_addr_i;
	logic [7:0]  dl_data_i;
	logic [15:0] cpu_addr_i;
	logic [7:0]  cpu_wdata_i;
	logic        cpu_rnw_i;
	logic        cs_ram_n_i;
	logic        cs0_n_i;
	logic        cs1_n_i;
	logic        cs_io_n_i;
	logic        model_i;
	wire  [7:0]  cpu_rdata_o;
	wire         dl_wait_o;

	logic [7:0]  prg_ref [PRG_LEN];
	logic [7:0]  cpu_ref [MIX_LEN];
	logic [7:0]  img_ref [5][ROM_LEN];
	logic [31:0] lcg_state = 32'h7fe5;
	string       cur_test;
	int          test_errors  = 0;
	int          total_errors = 0;
	int          checks       = 0;
	int          tests_run    = 0;
	int          tests_failed = 0;

	c16_mem_top #(.RAM_WORDS(65536), .ROM_WORDS(16384)) u_dut (
		.clk_sys(clk_sys), .reset(reset),
		.dl_active_i(dl_active_i), .dl_index_i(dl_index_i), .dl_wr_i(dl_wr_i),
		.dl_addr_i(dl_addr_i), .dl_data_i(dl_data_i),
		.cpu_addr_i(cpu_addr_i), .cpu_wdata_i(cpu_wdata_i), .cpu_rnw_i(cpu_rnw_i),
		.cs_ram_n_i(cs_ram_n_i), .cs0_n_i(cs0_n_i), .cs1_n_i(cs1_n_i),
		.cs_io_n_i(cs_io_n_i), .model_i(model_i),
		.cpu_rdata_o(cpu_rdata_o), .dl_wait_o(dl_wait_o)
	);

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	////////////////////////////////////////////////////////////////////////////
	// Helpers

	function automatic logic [7:0] rand_byte();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	// Inputs change 2 ns after the rising edge
	task automatic tick();
		@(posedge clk_sys);
		#2;
	endtask

	task automatic apply_reset(input logic model);
		model_i = model;
		reset   = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		#2;
		reset = 1'b0;
	endtask

	task automatic check_byte(input logic [15:0] addr, input logic [7:0] exp,
		input logic [7:0] got);
		checks++;
		assert (got === exp)
		else begin
			$display("[ERROR] %s @%h: expected %h, actual %h", cur_test, addr, exp, got);
			test_errors++;
		end
	endtask

	// Loader must hold the host off right after the given event
	task automatic expect_wait_high(input string stage);
		@(negedge clk_sys);
		checks++;
		assert (dl_wait_o === 1'b1)
		else begin
			$display("[ERROR] %s dl_wait_o after %s: expected 1, actual %b",
				cur_test, stage, dl_wait_o);
			test_errors++;
		end
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errors == 0) begin
			$display("%s: passed", cur_test);
		end else begin
			$display("%s: failed with %0d errors", cur_test, test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Download port

	task automatic dl_strobe(input logic [24:0] addr, input logic [7:0] data);
		dl_addr_i = addr;
		dl_data_i = data;
		dl_wr_i   = 1'b1;
		tick();
		dl_wr_i = 1'b0;
	endtask

	// dl_wait_o is sampled on the falling edge away from the drive points
	task automatic wait_dl_ready();
		@(negedge clk_sys);
		while (dl_wait_o)
			@(negedge clk_sys);
		tick();
	endtask

	task automatic dl_write(input logic [24:0] addr, input logic [7:0] data);
		dl_strobe(addr, data);
		wait_dl_ready();
	endtask

	task automatic prg_download(input logic [15:0] load_addr, input int len, input bit mix);
		dl_index_i  = PRG_INDEX;
		dl_active_i = 1'b1;
		dl_write(25'd0, load_addr[7:0]);
		dl_write(25'd1, load_addr[15:8]);
		for (int i = 0; i < len; i++) begin
			prg_ref[i] = rand_byte();
			dl_strobe(25'(i + 2), prg_ref[i]);
			// CPU traffic while the loader request is still pending
			if (mix) begin
				cpu_ref[i] = rand_byte();
				bus_write(MIX_CPU_BASE + 16'(i), SEL_RAM, cpu_ref[i]);
				read_check(MIX_CPU_BASE + 16'(i), SEL_RAM, cpu_ref[i]);
			end else begin
				expect_wait_high("body byte");
			end
			wait_dl_ready();
		end
		// Falling dl_active_i starts the pointer fix-up
		dl_active_i = 1'b0;
		expect_wait_high("download end");
		wait_dl_ready();
	endtask

	// ROM file address is the 11-bit slot above the 14-bit offset
	task automatic rom_load(input logic [7:0] index, input logic [10:0] slot,
		input logic [13:0] base, input int img);
		dl_index_i  = index;
		dl_active_i = 1'b1;
		for (int i = 0; i < ROM_LEN; i++) begin
			img_ref[img][i] = rand_byte();
			dl_write({slot, base + 14'(i)}, img_ref[img][i]);
		end
		dl_active_i = 1'b0;
		tick();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// CPU bus

	task automatic set_select(input int sel, input logic level);
		case (sel)
			SEL_RAM: cs_ram_n_i = level;
			SEL_CS0: cs0_n_i = level;
			SEL_CS1: cs1_n_i = level;
			default: cs_io_n_i = level;
		endcase
	endtask

	task automatic bus_write(input logic [15:0] addr, input int sel, input logic [7:0] data);
		cpu_addr_i  = addr;
		cpu_wdata_i = data;
		cpu_rnw_i   = 1'b0;
		set_select(sel, 1'b0);
		repeat (2) tick();
		set_select(sel, 1'b1);
		cpu_rnw_i = 1'b1;
		// The captured write lands in the idle cycles after the access
		repeat (2) tick();
	endtask

	task automatic bus_read(input logic [15:0] addr, input int sel, output logic [7:0] data);
		cpu_addr_i = addr;
		cpu_rnw_i  = 1'b1;
		set_select(sel, 1'b0);
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		data = cpu_rdata_o;
		tick();
		set_select(sel, 1'b1);
		tick();
	endtask

	task automatic read_check(input logic [15:0] addr, input int sel, input logic [7:0] exp);
		logic [7:0] got;
		bus_read(addr, sel, got);
		check_byte(addr, exp, got);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Tests

	task automatic test_prg_load();
		logic [15:0] end_addr;
		cur_test = "prg_load";
		prg_download(16'h1001, PRG_LEN, 1'b0);
		// Low byte of the end address at even table positions
		end_addr = 16'h1001 + 16'(PRG_LEN);
		for (int p = 0; p < 8; p++)
			read_check(PTR_LOC[p], SEL_RAM, p[0] ? end_addr[15:8] : end_addr[7:0]);
		for (int i = 0; i < PRG_LEN; i++)
			read_check(16'h1001 + 16'(i), SEL_RAM, prg_ref[i]);
		end_test();
	endtask

	task automatic test_ram_rw();
		logic [15:0] addr;
		logic [7:0]  data;
		cur_test = "ram_rw";
		for (int i = 0; i < RAND_LEN; i++) begin
			addr = {rand_byte(), rand_byte()};
			data = rand_byte();
			bus_write(addr, SEL_RAM, data);
			read_check(addr, SEL_RAM, data);
		end
		end_test();
	endtask

	task automatic test_mixed_access();
		cur_test = "mixed_access";
		prg_download(MIX_PRG_BASE, MIX_LEN, 1'b1);
		for (int i = 0; i < MIX_LEN; i++)
			read_check(MIX_PRG_BASE + 16'(i), SEL_RAM, prg_ref[i]);
		for (int i = 0; i < MIX_LEN; i++)
			read_check(MIX_CPU_BASE + 16'(i), SEL_RAM, cpu_ref[i]);
		end_test();
	endtask

	task automatic test_rom_select();
		cur_test = "rom_select";
		rom_load(ROM_INDEX, 11'd1, 14'h0000, IMG_KERNAL);
		rom_load(ROM_INDEX, 11'd1, 14'h3C10, IMG_KERNAL_FC);
		rom_load(ROM_INDEX, 11'd2, 14'h0000, IMG_BASIC);
		for (int i = 0; i < ROM_LEN; i++) begin
			read_check(16'hC000 + 16'(i), SEL_CS1, img_ref[IMG_KERNAL][i]);
			read_check(16'h8000 + 16'(i), SEL_CS0, img_ref[IMG_BASIC][i]);
		end
		end_test();
	endtask

	task automatic test_banking();
		cur_test = "banking";
		rom_load(CRT_INDEX, 11'd0, 14'h0000, IMG_CART_L);
		rom_load(CRT_INDEX, 11'd1, 14'h0000, IMG_CART_H);
		// $FDD5 puts both banks on the cartridge
		bus_write(16'hFDD5, SEL_IO, 8'h00);
		for (int i = 0; i < ROM_LEN; i++) begin
			read_check(16'h8000 + 16'(i), SEL_CS0, img_ref[IMG_CART_L][i]);
			read_check(16'hC000 + 16'(i), SEL_CS1, img_ref[IMG_CART_H][i]);
			read_check(16'hFC10 + 16'(i), SEL_CS1, img_ref[IMG_KERNAL_FC][i]);
		end
		// C16 model ignores the bank register
		apply_reset(1'b0);
		bus_write(16'hFDD5, SEL_IO, 8'h00);
		for (int i = 0; i < ROM_LEN; i++) begin
			read_check(16'h8000 + 16'(i), SEL_CS0, img_ref[IMG_BASIC][i]);
			read_check(16'hC000 + 16'(i), SEL_CS1, img_ref[IMG_KERNAL][i]);
		end
		end_test();
	endtask

	task automatic test_open_bus();
		cur_test = "open_bus";
		read_check(16'hFF3E, SEL_IO, 8'hFF);
		end_test();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog

	initial begin
		reset       = 1'b1;
		model_i     = 1'b1;
		dl_active_i = 1'b0;
		dl_index_i  = 8'h00;
		dl_wr_i     = 1'b0;
		dl_addr_i   = '0;
		dl_data_i   = 8'h00;
		cpu_addr_i  = 16'h0000;
		cpu_wdata_i = 8'h00;
		cpu_rnw_i   = 1'b1;
		cs_ram_n_i  = 1'b1;
		cs0_n_i     = 1'b1;
		cs1_n_i     = 1'b1;
		cs_io_n_i   = 1'b1;
		apply_reset(1'b1);
		test_prg_load();
		test_ram_rw();
		test_mixed_access();
		test_rom_select();
		test_banking();
		test_open_bus();
		$display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d",
			tests_run, tests_failed, checks, total_errors);
		if (tests_failed == 0 && total_errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog timeout: the run did not finish within %0d ns", WATCHDOG_NS);
		$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
c16_mem_pkg.sv
prg_loader.sv
ram_arbiter.sv
main_ram.sv
rom_store.sv
bank_ctrl.sv
c16_mem_top.sv
tb_c16_mem.sv

/* run_sim.sh */
#!/bin/sh
# Build the memory subsystem testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_c16_mem \
	-f filelist.f -o sim_c16_mem \
	&& ./obj_dir/sim_c16_mem | tee /dev/stderr | grep -qx "Test OK" \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed"; exit 1; }
